// ==== design/vrf_pkg.sv ====
`default_nettype none

package vrf_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry of the register file and the memory word
  ////////////////////////////////////////////////////////////

  localparam int unsigned VLEN = 128;
  localparam int unsigned PIPE_WIDTH = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Words that make up one vector register
  localparam int unsigned WORDS_PER_REG = VLEN / PIPE_WIDTH;
  localparam int unsigned WORD_SEL_W = $clog2(WORDS_PER_REG);

  // A group at LMUL 8 covers eight registers
  localparam int unsigned MAX_LMUL_WORDS = WORDS_PER_REG * 8;
  localparam int unsigned ITER_W = $clog2(MAX_LMUL_WORDS) + 1;
  localparam int unsigned MEM_ADDR_W = REG_ADDR_W + WORD_SEL_W;

  typedef logic [ITER_W-1:0] iter_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  localparam iter_t ITER_BASE = iter_t'(WORDS_PER_REG);
  localparam iter_t ITER_ONE = iter_t'(1);
  localparam mem_addr_t ADDR_ONE = mem_addr_t'(1);

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Signed LMUL, 3'b100 is reserved
  typedef enum logic [2:0] {
    LMUL_1   = 3'b000,
    LMUL_2   = 3'b001,
    LMUL_4   = 3'b010,
    LMUL_8   = 3'b011,
    LMUL_1_8 = 3'b101,
    LMUL_1_4 = 3'b110,
    LMUL_1_2 = 3'b111
  } vlmul_e;

  typedef enum logic {
    TAG_RS1 = 1'b0,
    TAG_RS2 = 1'b1
  } rd_tag_e;

  typedef enum logic [2:0] {
    IDLE,
    START,
    READ1,
    READ2,
    WRITE
  } seq_state_e;

  // Accesses selected for every element
  typedef struct packed {
    logic rd_rs1;
    logic rd_rs2;
    logic wr_rd;
  } op_sel_t;

  typedef struct packed {
    op_sel_t               op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    vlmul_e                lmul;
  } vrf_req_t;

  typedef struct packed {
    logic                  we;
    mem_addr_t             addr;
    logic [PIPE_WIDTH-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== design/vrf_op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_op_decode (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    req_i,
  input  wire vrf_pkg::vrf_req_t       req_data_i,
  input  wire logic                    seq_busy_i,
  output logic                         start_o,
  output vrf_pkg::vrf_req_t            cmd_o,
  output logic [vrf_pkg::ITER_W-1:0]   iters_o
);

  logic              legal;
  logic              accept;
  vrf_pkg::iter_t    words;
  logic              start_q;
  vrf_pkg::vrf_req_t cmd_q;
  vrf_pkg::iter_t    iters_q;

  // At least one access has to be selected
  assign legal  = |req_data_i.op;
  assign accept = req_i && !seq_busy_i && legal;

  ////////////////////////////////////////////////////////////
  // Iteration count
  ////////////////////////////////////////////////////////////

  // Word count of the register group
  always_comb begin
    case (req_data_i.lmul)
      vrf_pkg::LMUL_1_8: words = vrf_pkg::ITER_BASE >> 3;
      vrf_pkg::LMUL_1_4: words = vrf_pkg::ITER_BASE >> 2;
      vrf_pkg::LMUL_1_2: words = vrf_pkg::ITER_BASE >> 1;
      vrf_pkg::LMUL_2:   words = vrf_pkg::ITER_BASE << 1;
      vrf_pkg::LMUL_4:   words = vrf_pkg::ITER_BASE << 2;
      vrf_pkg::LMUL_8:   words = vrf_pkg::ITER_BASE << 3;
      default:           words = vrf_pkg::ITER_BASE;
    endcase
    // Small fractions still touch one word
    if (words == '0) begin
      words = vrf_pkg::ITER_ONE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
    end
  end

  // Held until the next accepted request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q   <= req_data_i;
      iters_q <= words;
    end
  end

  assign start_o = start_q;
  assign cmd_o   = cmd_q;
  assign iters_o = iters_q;

endmodule

`default_nettype wire

// ==== design/vrf_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_sequencer (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire logic                        start_i,
  input  wire vrf_pkg::vrf_req_t           cmd_i,
  input  wire logic [vrf_pkg::ITER_W-1:0]  iters_i,
  input  wire logic                        mem_gnt_i,
  input  wire logic                        mem_rvalid_i,
  input  wire logic [vrf_pkg::PIPE_WIDTH-1:0] result_i,
  output logic                             mem_valid_o,
  output vrf_pkg::mem_req_t                mem_req_o,
  output logic                             rd_issue_o,
  output vrf_pkg::rd_tag_e                 rd_tag_o,
  output logic                             last_read_o,
  output logic                             pair_req_o,
  output logic                             busy_o,
  output logic                             done_o
);

  vrf_pkg::seq_state_e            state_q;
  vrf_pkg::seq_state_e            state_d;
  vrf_pkg::seq_state_e            first_state;
  vrf_pkg::iter_t                 remain_q;
  vrf_pkg::iter_t                 remain_d;
  vrf_pkg::mem_addr_t             elem_q;
  vrf_pkg::mem_addr_t             elem_d;
  logic                           elem_end;
  logic                           last_elem;
  logic                           rd_only;
  logic                           done_q;
  logic                           rd_in_flight_q;
  logic [vrf_pkg::REG_ADDR_W-1:0] reg_sel;

  // RD-only elements have no reads to wait for
  assign rd_only = !cmd_i.op.rd_rs1 && !cmd_i.op.rd_rs2;

  // First access of every element
  always_comb begin
    if (cmd_i.op.rd_rs1) begin
      first_state = vrf_pkg::READ1;
    end else if (cmd_i.op.rd_rs2) begin
      first_state = vrf_pkg::READ2;
    end else begin
      first_state = vrf_pkg::WRITE;
    end
  end

  ////////////////////////////////////////////////////////////
  // Element FSM
  ////////////////////////////////////////////////////////////

  // Each access state holds its request until the grant
  always_comb begin
    state_d     = state_q;
    remain_d    = remain_q;
    elem_d      = elem_q;
    mem_valid_o = 1'b0;
    last_read_o = 1'b0;
    elem_end    = 1'b0;

    case (state_q)
      vrf_pkg::IDLE: begin
        if (start_i) begin
          remain_d = iters_i;
          elem_d   = '0;
          state_d  = vrf_pkg::START;
        end
      end

      vrf_pkg::START: begin
        state_d = first_state;
      end

      vrf_pkg::READ1: begin
        mem_valid_o = 1'b1;
        last_read_o = !cmd_i.op.rd_rs2;
        if (mem_gnt_i) begin
          if (cmd_i.op.rd_rs2) begin
            state_d = vrf_pkg::READ2;
          end else if (cmd_i.op.wr_rd) begin
            state_d = vrf_pkg::WRITE;
          end else begin
            elem_end = 1'b1;
          end
        end
      end

      vrf_pkg::READ2: begin
        mem_valid_o = 1'b1;
        last_read_o = 1'b1;
        if (mem_gnt_i) begin
          if (cmd_i.op.wr_rd) begin
            state_d = vrf_pkg::WRITE;
          end else begin
            elem_end = 1'b1;
          end
        end
      end

      vrf_pkg::WRITE: begin
        mem_valid_o = 1'b1;
        if (mem_gnt_i) begin
          elem_end = 1'b1;
        end
      end

      default: begin
        state_d = vrf_pkg::IDLE;
      end
    endcase

    // Move on to the next element or finish
    if (elem_end) begin
      if (last_elem) begin
        state_d = vrf_pkg::IDLE;
      end else begin
        remain_d = remain_q - vrf_pkg::ITER_ONE;
        elem_d   = elem_q + vrf_pkg::ADDR_ONE;
        state_d  = vrf_pkg::START;
      end
    end
  end

  assign last_elem = (remain_q == vrf_pkg::ITER_ONE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= vrf_pkg::IDLE;
      remain_q       <= '0;
      elem_q         <= '0;
      done_q         <= 1'b0;
      rd_in_flight_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      remain_q <= remain_d;
      elem_q   <= elem_d;
      done_q   <= elem_end && last_elem;
      // Cleared by the returning data unless a new read goes out
      if (rd_issue_o) begin
        rd_in_flight_q <= 1'b1;
      end else if (mem_rvalid_i) begin
        rd_in_flight_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory request
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (state_q)
      vrf_pkg::READ1: reg_sel = cmd_i.rs1;
      vrf_pkg::READ2: reg_sel = cmd_i.rs2;
      default:        reg_sel = cmd_i.rd;
    endcase
    mem_req_o.we    = (state_q == vrf_pkg::WRITE);
    // Register base plus the element index
    mem_req_o.addr  = {reg_sel, {vrf_pkg::WORD_SEL_W{1'b0}}} + elem_q;
    mem_req_o.wdata = result_i;
  end

  assign rd_issue_o = mem_valid_o && mem_gnt_i && !mem_req_o.we;
  assign rd_tag_o   = (state_q == vrf_pkg::READ2) ? vrf_pkg::TAG_RS2 : vrf_pkg::TAG_RS1;

  // Operand pair shows up in START for RD-only ops
  assign pair_req_o = (state_d == vrf_pkg::START) && rd_only;

  // Stay busy until the last read has returned
  assign busy_o = (state_q != vrf_pkg::IDLE) || start_i || rd_in_flight_q;
  assign done_o = done_q;

endmodule

`default_nettype wire

// ==== design/vrf_operand_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_operand_regs (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic                            rd_issue_i,
  input  wire vrf_pkg::rd_tag_e                rd_tag_i,
  input  wire logic                            last_read_i,
  input  wire logic                            pair_req_i,
  input  wire logic                            mem_rvalid_i,
  input  wire logic [vrf_pkg::PIPE_WIDTH-1:0]  mem_rdata_i,
  output logic                                 operand_valid_o,
  output logic [2*vrf_pkg::PIPE_WIDTH-1:0]     operand_o
);

  vrf_pkg::rd_tag_e               tag_q;
  logic                           last_q;
  logic                           valid_q;
  logic [vrf_pkg::PIPE_WIDTH-1:0] rs1_q;
  logic [vrf_pkg::PIPE_WIDTH-1:0] rs2_q;

  // Tag of the one outstanding read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_q   <= vrf_pkg::TAG_RS1;
      last_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (rd_issue_i) begin
        tag_q  <= rd_tag_i;
        last_q <= last_read_i;
      end
      valid_q <= (mem_rvalid_i && last_q) || pair_req_i;
    end
  end

  // Returned word goes where the tag points
  always_ff @(posedge clk_i) begin
    if (mem_rvalid_i) begin
      if (tag_q == vrf_pkg::TAG_RS1) begin
        rs1_q <= mem_rdata_i;
      end else begin
        rs2_q <= mem_rdata_i;
      end
    end
  end

  assign operand_valid_o = valid_q;
  // RS1 in the upper half
  assign operand_o = {rs1_q, rs2_q};

endmodule

`default_nettype wire

// ==== design/vrf_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_interface (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  // Pipeline request
  input  wire logic                            req_i,
  input  wire vrf_pkg::vrf_req_t               req_data_i,
  output logic                                 busy_o,
  // Operands out and result back
  input  wire logic [vrf_pkg::PIPE_WIDTH-1:0]  result_i,
  output logic                                 operand_valid_o,
  output logic [2*vrf_pkg::PIPE_WIDTH-1:0]     operand_o,
  output logic                                 done_o,
  // Data memory port
  output logic                                 mem_valid_o,
  output vrf_pkg::mem_req_t                    mem_req_o,
  input  wire logic                            mem_gnt_i,
  input  wire logic                            mem_rvalid_i,
  input  wire logic [vrf_pkg::PIPE_WIDTH-1:0]  mem_rdata_i
);

  logic                          start;
  vrf_pkg::vrf_req_t             cmd;
  logic [vrf_pkg::ITER_W-1:0]    iters;
  logic                          rd_issue;
  vrf_pkg::rd_tag_e              rd_tag;
  logic                          last_read;
  logic                          pair_req;

  vrf_op_decode u_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .seq_busy_i (busy_o),
    .start_o    (start),
    .cmd_o      (cmd),
    .iters_o    (iters)
  );

  vrf_sequencer u_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .cmd_i        (cmd),
    .iters_i      (iters),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .result_i     (result_i),
    .mem_valid_o  (mem_valid_o),
    .mem_req_o    (mem_req_o),
    .rd_issue_o   (rd_issue),
    .rd_tag_o     (rd_tag),
    .last_read_o  (last_read),
    .pair_req_o   (pair_req),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  vrf_operand_regs u_operands (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rd_issue_i      (rd_issue),
    .rd_tag_i        (rd_tag),
    .last_read_i     (last_read),
    .pair_req_i      (pair_req),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .operand_valid_o (operand_valid_o),
    .operand_o       (operand_o)
  );

endmodule

`default_nettype wire

// ==== tests/vrf_interface_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_interface_asserts (
  input wire logic              clk_i,
  input wire logic              rst_ni,
  input wire logic              mem_valid_o,
  input wire vrf_pkg::mem_req_t mem_req_o,
  input wire logic              mem_gnt_i,
  input wire logic              mem_rvalid_i,
  input wire logic              busy_o,
  input wire logic              done_o,
  input wire logic              operand_valid_o
);

  logic read_gnt;
  logic pending_q;

  assign read_gnt = mem_valid_o && mem_gnt_i && !mem_req_o.we;

  // One read in flight until its data returns
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (read_gnt) begin
      pending_q <= 1'b1;
    end else if (mem_rvalid_i) begin
      pending_q <= 1'b0;
    end
  end

  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid_o && !mem_gnt_i |=> mem_valid_o && $stable(mem_req_o))
    else $error("memory request changed while waiting for a grant");

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !done_o && !operand_valid_o && !busy_o && !mem_valid_o)
    else $error("done, operand valid, busy or memory valid high during reset");

  // Busy has to cover a read until its data is back
  read_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending_q |-> busy_o)
    else $error("busy dropped while a read was still outstanding");

endmodule

bind vrf_interface vrf_interface_asserts u_asserts (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .mem_valid_o     (mem_valid_o),
  .mem_req_o       (mem_req_o),
  .mem_gnt_i       (mem_gnt_i),
  .mem_rvalid_i    (mem_rvalid_i),
  .busy_o          (busy_o),
  .done_o          (done_o),
  .operand_valid_o (operand_valid_o)
);

`default_nettype wire

// ==== tests/tb_vrf_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vrf_interface;

  // Elements over all tests, used for the cycle limit
  localparam int TOTAL_ELEMS = 124;
  localparam int CYCLE_LIMIT = TOTAL_ELEMS * 12 + 200;
  localparam int WPR = vrf_pkg::WORDS_PER_REG;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             req_i;
  vrf_pkg::vrf_req_t                req_data_i;
  logic                             busy_o;
  logic [vrf_pkg::PIPE_WIDTH-1:0]   result_i;
  logic                             operand_valid_o;
  logic [2*vrf_pkg::PIPE_WIDTH-1:0] operand_o;
  logic                             done_o;
  logic                             mem_valid_o;
  vrf_pkg::mem_req_t                mem_req_o;
  logic                             mem_gnt_i;
  logic                             mem_rvalid_i;
  logic [vrf_pkg::PIPE_WIDTH-1:0]   mem_rdata_i;

  logic [vrf_pkg::PIPE_WIDTH-1:0] mem [128];
  vrf_pkg::vrf_req_t cur_req;
  vrf_pkg::mem_req_t exp_q[$];
  vrf_pkg::mem_req_t wr_log[$];
  vrf_pkg::mem_req_t ref_writes[$];
  bit stall_en;
  bit busy_seen;
  int wr_cnt;
  int op_cnt;
  int done_cnt;
  int acc_cnt;
  int errors;
  int tests_run;
  int tests_failed;
  int cycles;

  vrf_interface DUT (.*);

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Word count of a register group, never below one
  function automatic int words_for(vrf_pkg::vlmul_e lmul);
    case (lmul)
      vrf_pkg::LMUL_1_8: return (WPR / 8 > 0) ? WPR / 8 : 1;
      vrf_pkg::LMUL_1_4: return (WPR / 4 > 0) ? WPR / 4 : 1;
      vrf_pkg::LMUL_1_2: return (WPR / 2 > 0) ? WPR / 2 : 1;
      vrf_pkg::LMUL_2:   return WPR * 2;
      vrf_pkg::LMUL_4:   return WPR * 4;
      vrf_pkg::LMUL_8:   return WPR * 8;
      default:           return WPR;
    endcase
  endfunction

  // Operand pair of element k, unselected halves read as zero
  function automatic logic [63:0] pair_word(int k);
    logic [31:0] a;
    logic [31:0] b;
    a = cur_req.op.rd_rs1 ? mem[int'(cur_req.rs1) * WPR + k] : 32'h0;
    b = cur_req.op.rd_rs2 ? mem[int'(cur_req.rs2) * WPR + k] : 32'h0;
    return {a, b};
  endfunction

  function automatic logic [31:0] ref_result(int k, logic [63:0] pair);
    return (pair[63:32] + {pair[15:0], pair[31:16]}) ^ (32'h9e3779b9 * k);
  endfunction

  function automatic vrf_pkg::mem_req_t make_req(bit we, int addr, logic [31:0] wdata);
    vrf_pkg::mem_req_t r;
    r.we    = we;
    r.addr  = vrf_pkg::mem_addr_t'(addr);
    r.wdata = wdata;
    return r;
  endfunction

  task automatic load_expect(vrf_pkg::vrf_req_t req, int n);
    exp_q.delete();
    for (int k = 0; k < n; k++) begin
      if (req.op.rd_rs1) exp_q.push_back(make_req(1'b0, int'(req.rs1) * WPR + k, '0));
      if (req.op.rd_rs2) exp_q.push_back(make_req(1'b0, int'(req.rs2) * WPR + k, '0));
      if (req.op.wr_rd) begin
        exp_q.push_back(make_req(1'b1, int'(req.rd) * WPR + k,
                                 ref_result(k, pair_word(k))));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  // Write data only matters on writes
  task automatic check_mem_req(vrf_pkg::mem_req_t got, vrf_pkg::mem_req_t exp);
    if (got.we !== exp.we || got.addr !== exp.addr || (exp.we && got.wdata !== exp.wdata)) begin
      $display("FAILED mem_req_o got %h expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_operands(logic [63:0] got, logic [63:0] exp, logic [63:0] mask);
    if ((got & mask) !== (exp & mask)) begin
      $display("FAILED operand_o got %h expected %h", got & mask, exp & mask);
      errors++;
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report(string name, int err0);
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
      $display("FAIL %s", name);
    end else begin
      $display("PASS %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model and monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (busy_o) busy_seen = 1'b1;
      if (mem_valid_o && mem_gnt_i) begin
        acc_cnt++;
        if (exp_q.size() == 0) begin
          $display("Unexpected memory access at address %h", mem_req_o.addr);
          errors++;
        end else begin
          check_mem_req(mem_req_o, exp_q.pop_front());
        end
        if (mem_req_o.we) begin
          mem[mem_req_o.addr] = mem_req_o.wdata;
          wr_log.push_back(mem_req_o);
          wr_cnt++;
          result_i <= ref_result(wr_cnt, pair_word(wr_cnt));
        end
      end
      mem_rvalid_i <= mem_valid_o && mem_gnt_i && !mem_req_o.we;
      mem_rdata_i  <= mem[mem_req_o.addr];
      mem_gnt_i    <= stall_en ? ($urandom_range(9) < 7) : 1'b1;
      if (operand_valid_o) begin
        check_operands(operand_o, pair_word(op_cnt),
                       {{32{cur_req.op.rd_rs1}}, {32{cur_req.op.rd_rs2}}});
        op_cnt++;
      end
      if (done_o) done_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic run_op(string name, vrf_pkg::vrf_req_t req, bit stall);
    int n;
    int err0;
    n = words_for(req.lmul);
    err0 = errors;
    cur_req = req;
    stall_en = stall;
    wr_cnt = 0;
    op_cnt = 0;
    done_cnt = 0;
    acc_cnt = 0;
    wr_log.delete();
    load_expect(req, n);
    @(posedge clk_i);
    result_i   <= ref_result(0, pair_word(0));
    req_data_i <= req;
    req_i      <= 1'b1;
    @(posedge clk_i);
    req_i <= 1'b0;
    while (done_cnt == 0) @(posedge clk_i);
    while (busy_o) @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    check_count("writes", wr_cnt, req.op.wr_rd ? n : 0);
    check_count("operand pairs", op_cnt, n);
    check_count("done pulses", done_cnt, 1);
    if (exp_q.size() != 0) begin
      $display("%0d expected memory accesses never happened", exp_q.size());
      errors++;
    end
    report(name, err0);
  endtask

  function automatic vrf_pkg::vrf_req_t make_op(logic [2:0] op, vrf_pkg::vlmul_e lmul);
    vrf_pkg::vrf_req_t r;
    r.op   = op;
    r.rs1  = 5'd0;
    r.rs2  = 5'd8;
    r.rd   = 5'd16;
    r.lmul = lmul;
    return r;
  endfunction

  initial begin
    vrf_pkg::vlmul_e lmuls [7];
    int err0;
    void'($urandom(32'hc2737ee7));
    lmuls = '{vrf_pkg::LMUL_1_8, vrf_pkg::LMUL_1_4, vrf_pkg::LMUL_1_2, vrf_pkg::LMUL_1,
              vrf_pkg::LMUL_2, vrf_pkg::LMUL_4, vrf_pkg::LMUL_8};
    for (int i = 0; i < 128; i++) mem[i] = $urandom();
    clk_i = 1'b0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    req_data_i = '0;
    result_i = '0;
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i = '0;
    cur_req = '0;
    stall_en = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);

    run_op("read-read-write lmul 1", make_op(3'b111, vrf_pkg::LMUL_1), 1'b0);
    foreach (lmuls[i]) begin
      run_op($sformatf("iteration count %s", lmuls[i].name()),
             make_op(3'b111, lmuls[i]), 1'b0);
    end
    run_op("rd only", make_op(3'b001, vrf_pkg::LMUL_2), 1'b1);
    run_op("rs1 read only", make_op(3'b100, vrf_pkg::LMUL_2), 1'b1);
    run_op("rs2 read and write", make_op(3'b011, vrf_pkg::LMUL_2), 1'b1);

    // Same op without and with grant stalls
    run_op("no stall reference", make_op(3'b111, vrf_pkg::LMUL_4), 1'b0);
    ref_writes = wr_log;
    run_op("back-pressure", make_op(3'b111, vrf_pkg::LMUL_4), 1'b1);
    err0 = errors;
    check_count("stalled write total", wr_log.size(), ref_writes.size());
    foreach (ref_writes[i]) begin
      if (i < wr_log.size()) check_mem_req(wr_log[i], ref_writes[i]);
    end
    report("back-pressure write order", err0);

    // Illegal request has nothing to wait for
    err0 = errors;
    acc_cnt = 0;
    done_cnt = 0;
    busy_seen = 1'b0;
    stall_en = 1'b0;
    @(posedge clk_i);
    req_data_i <= make_op(3'b000, vrf_pkg::LMUL_1);
    req_i      <= 1'b1;
    @(posedge clk_i);
    req_i <= 1'b0;
    repeat (20) @(posedge clk_i);
    check_count("illegal accesses", acc_cnt, 0);
    check_count("illegal done pulses", done_cnt, 0);
    check_count("illegal busy", int'(busy_seen), 0);
    report("illegal request", err0);

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/vrf_pkg.sv
design/vrf_op_decode.sv
design/vrf_sequencer.sv
design/vrf_operand_regs.sv
design/vrf_interface.sv
tests/vrf_interface_asserts.sv
tests/tb_vrf_interface.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_vrf_interface -f list.f \
  && ./obj_dir/Vtb_vrf_interface > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
